// ==== src.f ====
+incdir+design
design/floatPkg.sv
design/neuronPkg.sv
design/macBus.sv
design/floatMultiply.sv
design/floatAdd.sv
design/weightStore.sv
design/neuronAccumulator.sv
design/neuronControl.sv
design/neuronTop.sv
test/neuron_properties.sv
test/neuronTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module neuronTb -f src.f -o neuronSim \
	&& ./obj_dir/neuronSim \
	|| exit 1

// ==== test/neuronTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neuron_params.svh"

module neuronTb;
	import floatPkg::*;
	import neuronPkg::*;

	localparam int ClockPeriod = 40;
	localparam int ResetCycles = 8;
	localparam int RandomRuns = 6;
	// Weight writes, samples with gaps, and the result wait.
	localparam int CyclesPerNeuron = 120;
	localparam int TimeLimit = (ResetCycles + (5 + RandomRuns) * CyclesPerNeuron + 50) * ClockPeriod;

	logic clk;
	logic rstN;
	logic sampleValid;
	floatWord sampleData;
	logic weightWrite;
	weightIndex weightAddr;
	floatWord weightData;
	floatWord result;
	logic resultValid;
	logic busy;

	// Operands in units of one half with the bias in the last weight slot.
	int inputHalves [`NUM_INPUTS];
	int weightHalves [`NUM_INPUTS+1];
	logic [31:0] rngState = 32'h9df0c19d;

	neuronTop i_dut (
		.clk(clk),
		.rstN(rstN),
		.sampleValid(sampleValid),
		.sampleData(sampleData),
		.weightWrite(weightWrite),
		.weightAddr(weightAddr),
		.weightData(weightData),
		.result(result),
		.resultValid(resultValid),
		.busy(busy)
	);

	always #(ClockPeriod/2) clk = ~clk;

	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	function automatic int randomRange(input int low, input int high);
		logic [31:0] r;
		r = nextRandom();
		return low + int'(r % 32'(high - low + 1));
	endfunction

	// Fixed point with fracBits fraction bits to single precision bits.
	function automatic floatWord fixedToFloat(input longint value, input int fracBits);
		longint mag;
		int msb;
		logic [22:0] frac;
		if (value == 0)
			return '0;
		mag = (value < 0) ? -value : value;
		msb = 0;
		for (int i = 0; i < 63; i++)
		begin
			if (mag[i])
				msb = i;
		end
		if (msb > 23)
			frac = 23'(mag >> (msb - 23));
		else
			frac = 23'(mag << (23 - msb));
		return {value < 0, 8'(msb - fracBits + 127), frac};
	endfunction

	task automatic stopRun();
		$display("TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected)
		else
		begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, actual, expected);
			stopRun();
		end
	endtask

	task automatic checkCondition(input bit cond, input string what);
		assert (cond)
		else
		begin
			$display("Error: %s", what);
			stopRun();
		end
	endtask

	task automatic writeWeights();
		for (int i = 0; i <= `NUM_INPUTS; i++)
		begin
			@(negedge clk);
			weightWrite = 1'b1;
			weightAddr = weightIndex'(i);
			weightData = fixedToFloat(longint'(weightHalves[i]), 1);
		end
		@(negedge clk);
		weightWrite = 1'b0;
	endtask

	// Streams one neuron's samples and checks the result against the model.
	task automatic runNeuron(input bit randomTiming);
		longint sum;
		floatWord expected;
		int sent;
		int waited;
		sum = longint'(2 * weightHalves[`NUM_INPUTS]);
		for (int i = 0; i < `NUM_INPUTS; i++)
			sum += longint'(inputHalves[i]) * longint'(weightHalves[i]);
		// Sum in quarters.
		expected = (sum < 0) ? '0 : fixedToFloat(sum, 2);
		sent = 0;
		while (sent < `NUM_INPUTS)
		begin
			@(negedge clk);
			if (randomTiming && randomRange(0, 3) == 0)
			begin
				sampleValid = 1'b0;
				sampleData = nextRandom();
			end
			else
			begin
				sampleValid = 1'b1;
				sampleData = fixedToFloat(longint'(inputHalves[sent]), 1);
				sent++;
			end
		end
		// Accept edge, bias edge, then the load edge.
		waited = 0;
		while (!resultValid && waited < 8)
		begin
			@(negedge clk);
			waited++;
			if (waited == 1)
				checkValue("busy", 32'(busy), 32'h1);
			// Stray samples while busy must be dropped.
			sampleValid = randomTiming && busy;
			sampleData = nextRandom();
		end
		checkCondition(resultValid, "resultValid never rose after the last sample");
		checkCondition(waited == 3, "resultValid did not come two cycles after the last sample");
		checkValue("busy", 32'(busy), 32'h0);
		checkValue("result", result, expected);
		@(negedge clk);
		checkValue("resultValid", 32'(resultValid), 32'h0);
	endtask

	task automatic checkReset();
		checkValue("resultValid", 32'(resultValid), 32'h0);
		checkValue("busy", 32'(busy), 32'h0);
		checkValue("result", result, 32'h0);
	endtask

	task automatic positiveSum();
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			inputHalves[i] = 2 * (i + 1);
			weightHalves[i] = 2 * (i % 4 + 1);
		end
		weightHalves[`NUM_INPUTS] = 6;
		writeWeights();
		runNeuron(1'b0);
	endtask

	task automatic negativeSum();
		for (int i = 0; i < `NUM_INPUTS; i++)
			weightHalves[i] = -2 * (i % 3 + 1);
		weightHalves[`NUM_INPUTS] = 10;
		writeWeights();
		runNeuron(1'b0);
	endtask

	// Opposite halves cancel in pairs and the last product cancels the bias.
	task automatic cancellingSum();
		for (int i = 0; i < `NUM_INPUTS - 1; i++)
		begin
			inputHalves[i] = (i % 2 == 0) ? i + 1 : -i;
			weightHalves[i] = 4;
		end
		inputHalves[`NUM_INPUTS-1] = 1;
		weightHalves[`NUM_INPUTS-1] = -4;
		weightHalves[`NUM_INPUTS] = 2;
		writeWeights();
		runNeuron(1'b0);
	endtask

	task automatic fractionalSum();
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			inputHalves[i] = 2 * i * i + 1;
			weightHalves[i] = (i % 3 == 0) ? -3 : 5;
		end
		weightHalves[`NUM_INPUTS] = -7;
		writeWeights();
		runNeuron(1'b0);
	endtask

	task automatic randomStream();
		for (int run = 0; run < RandomRuns; run++)
		begin
			if (run % 2 == 0)
			begin
				for (int i = 0; i <= `NUM_INPUTS; i++)
					weightHalves[i] = 2 * randomRange(-8, 8);
				writeWeights();
			end
			for (int i = 0; i < `NUM_INPUTS; i++)
				inputHalves[i] = 2 * randomRange(-8, 8);
			runNeuron(1'b1);
		end
	endtask

	initial
	begin
		#(TimeLimit);
		$display("Error: the tests did not finish within %0d ns", TimeLimit);
		stopRun();
	end

	initial
	begin
		clk = 1'b0;
		rstN = 1'b0;
		sampleValid = 1'b0;
		sampleData = '0;
		weightWrite = 1'b0;
		weightAddr = '0;
		weightData = '0;
		repeat (ResetCycles) @(negedge clk);
		rstN = 1'b1;
		checkReset();
		positiveSum();
		negativeSum();
		cancellingSum();
		fractionalSum();
		randomStream();
		$display("TESTS PASSED");
		$finish;
	end
endmodule

`default_nettype wire

// ==== test/neuron_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neuron_params.svh"

module neuronProperties (
	input logic clk,
	input logic rstN,
	input logic sampleValid,
	input logic busy,
	input logic resultValid,
	input logic accumulate,
	input logic useBias,
	input neuronPkg::weightIndex count
);
	localparam int LastSample = `NUM_INPUTS - 1;

	resultPulse: assert property (@(posedge clk) disable iff (!rstN)
		resultValid |=> !resultValid)
	else $error("resultValid stayed high for more than one cycle");

	// Busy rises on the last accepted sample and never otherwise.
	busyRise: assert property (@(posedge clk) disable iff (!rstN)
		!busy |=> (busy == $past(sampleValid && int'(count) == LastSample)))
	else $error("busy did not follow the last accepted sample");

	noProductWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
		busy |-> !(accumulate && !useBias))
	else $error("product accumulated while busy");
endmodule

bind neuronControl neuronProperties controlChecks (
	.clk(clk),
	.rstN(rstN),
	.sampleValid(sampleValid),
	.busy(busy),
	.resultValid(resultValid),
	.accumulate(mac.accumulate),
	.useBias(mac.useBias),
	.count(count)
);

`default_nettype wire

// ==== design/neuronTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuronTop (
	input logic clk,
	input logic rstN,
	input logic sampleValid,
	input floatPkg::floatWord sampleData,
	input logic weightWrite,
	input neuronPkg::weightIndex weightAddr,
	input floatPkg::floatWord weightData,
	output floatPkg::floatWord result,
	output logic resultValid,
	output logic busy
);
	import floatPkg::*;
	import neuronPkg::*;

	floatWord weight;
	floatWord product;
	weightIndex readIndex;

	macBus mac ();

	neuronControl controlUnit (
		.clk(clk),
		.rstN(rstN),
		.sampleValid(sampleValid),
		.weightIndex(readIndex),
		.busy(busy),
		.resultValid(resultValid),
		.mac(mac.control)
	);

	weightStore store (
		.clk(clk),
		.rstN(rstN),
		.weightWrite(weightWrite),
		.weightAddr(weightAddr),
		.weightData(weightData),
		.readIndex(readIndex),
		.weight(weight)
	);

	floatMultiply multiplier (
		.a(sampleData),
		.b(weight),
		.product(product)
	);

	neuronAccumulator accumulator (
		.clk(clk),
		.rstN(rstN),
		.product(product),
		.weight(weight),
		.mac(mac.sink),
		.result(result)
	);
endmodule

`default_nettype wire

// ==== design/neuronControl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neuron_params.svh"

module neuronControl (
	input logic clk,
	input logic rstN,
	input logic sampleValid,
	output neuronPkg::weightIndex weightIndex,
	output logic busy,
	output logic resultValid,
	macBus.control mac
);
	import neuronPkg::*;

	localparam int LastSample = `NUM_INPUTS - 1;
	localparam int BiasSlot = `NUM_INPUTS;

	controlState state;
	logic [$bits(weightIndex)-1:0] count;
	logic accept;

	assign busy = (state == addBias) || (state == finish);
	assign accept = sampleValid && !busy;

	assign mac.clear = (state == finish);
	assign mac.accumulate = accept || (state == addBias);
	assign mac.useBias = (state == addBias);
	assign mac.finish = (state == finish);

	assign weightIndex = (state == addBias) ? BiasSlot[$bits(weightIndex)-1:0] : count;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= idle;
			count <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			// Lines up with the output register load.
			resultValid <= (state == finish);
			case (state)
				idle, collect:
				begin
					if (accept)
					begin
						if (int'(count) == LastSample)
						begin
							state <= addBias;
							count <= '0;
						end
						else
						begin
							state <= collect;
							count <= count + 1'b1;
						end
					end
				end
				addBias:
					state <= finish;
				default:
					state <= idle;
			endcase
		end
	end
endmodule

`default_nettype wire

// ==== design/neuronAccumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neuron_params.svh"

module neuronAccumulator (
	input logic clk,
	input logic rstN,
	input floatPkg::floatWord product,
	input floatPkg::floatWord weight,
	macBus.sink mac,
	output floatPkg::floatWord result
);
	import floatPkg::*;

	floatWord acc;
	floatWord operand;
	floatWord accSum;

	// Bias comes straight from the store.
	assign operand = mac.useBias ? weight : product;

	floatAdd adder (
		.a(acc),
		.b(operand),
		.sum(accSum)
	);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			acc <= '0;
			result <= '0;
		end
		else
		begin
			if (mac.clear)
				acc <= '0;
			else if (mac.accumulate)
				acc <= accSum;
			// ReLU on the way out.
			if (mac.finish)
				result <= acc[`FLOAT_WIDTH-1] ? '0 : acc;
		end
	end
endmodule

`default_nettype wire

// ==== design/weightStore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neuron_params.svh"

module weightStore (
	input logic clk,
	input logic rstN,
	input logic weightWrite,
	input neuronPkg::weightIndex weightAddr,
	input floatPkg::floatWord weightData,
	input neuronPkg::weightIndex readIndex,
	output floatPkg::floatWord weight
);
	import floatPkg::*;

	// Slot NUM_INPUTS holds the bias.
	floatWord slots [`NUM_INPUTS+1];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i <= `NUM_INPUTS; i++)
				slots[i] <= '0;
		end
		else if (weightWrite)
		begin
			slots[weightAddr] <= weightData;
		end
	end

	assign weight = slots[readIndex];
endmodule

`default_nettype wire

// ==== design/floatAdd.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neuron_params.svh"

module floatAdd (
	input floatPkg::floatWord a,
	input floatPkg::floatWord b,
	output floatPkg::floatWord sum
);
	import floatPkg::*;

	floatWord big;
	floatWord little;
	floatExp expBig;
	floatExp expSmall;
	floatExp expDiff;
	floatExp expOut;
	floatMant mantBig;
	floatMant mantSmall;
	floatMant mantAligned;
	logic [`MANT_WIDTH+1:0] mantSum;
	logic [`MANT_WIDTH:0] mantNorm;
	logic [$clog2(`MANT_WIDTH+2)-1:0] lzCount;
	logic found;

	always_comb
	begin
		// Larger magnitude first so the difference never goes negative.
		if (a[`FLOAT_WIDTH-2:0] >= b[`FLOAT_WIDTH-2:0])
		begin
			big = a;
			little = b;
		end
		else
		begin
			big = b;
			little = a;
		end

		expBig = big[`FLOAT_WIDTH-2 -: `EXP_WIDTH];
		expSmall = little[`FLOAT_WIDTH-2 -: `EXP_WIDTH];
		mantBig = (expBig == '0) ? '0 : {1'b1, big[`MANT_WIDTH-1:0]};
		mantSmall = (expSmall == '0) ? '0 : {1'b1, little[`MANT_WIDTH-1:0]};

		// Shifted out bits are dropped.
		expDiff = expBig - expSmall;
		mantAligned = mantSmall >> expDiff;

		if (big[`FLOAT_WIDTH-1] ^ little[`FLOAT_WIDTH-1])
			mantSum = {1'b0, mantBig} - {1'b0, mantAligned};
		else
			mantSum = {1'b0, mantBig} + {1'b0, mantAligned};

		lzCount = '0;
		found = 1'b0;
		for (int i = `MANT_WIDTH; i >= 0; i--)
		begin
			if (!found)
			begin
				if (mantSum[i])
					found = 1'b1;
				else
					lzCount = lzCount + 1'b1;
			end
		end
		mantNorm = mantSum[`MANT_WIDTH:0] << lzCount;

		sum = '0;
		expOut = expBig;
		if (mantSum[`MANT_WIDTH+1])
		begin
			// A carry out shifts the sum right by one.
			expOut = expBig + 1'b1;
			sum = {big[`FLOAT_WIDTH-1], expOut, mantSum[`MANT_WIDTH:1]};
		end
		else if (found && expBig > floatExp'(lzCount))
		begin
			expOut = expBig - floatExp'(lzCount);
			sum = {big[`FLOAT_WIDTH-1], expOut, mantNorm[`MANT_WIDTH-1:0]};
		end
	end
endmodule

`default_nettype wire

// ==== design/floatMultiply.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neuron_params.svh"

module floatMultiply (
	input floatPkg::floatWord a,
	input floatPkg::floatWord b,
	output floatPkg::floatWord product
);
	import floatPkg::*;

	localparam logic [`EXP_WIDTH+1:0] Bias = {3'b000, {(`EXP_WIDTH-1){1'b1}}};

	floatExp expA;
	floatExp expB;
	floatMant mantA;
	floatMant mantB;
	logic [2*`MANT_WIDTH+1:0] mantProd;
	logic [`EXP_WIDTH+1:0] expSum;
	logic [`MANT_WIDTH-1:0] mantOut;
	logic norm;

	assign expA = a[`FLOAT_WIDTH-2 -: `EXP_WIDTH];
	assign expB = b[`FLOAT_WIDTH-2 -: `EXP_WIDTH];
	assign mantA = {1'b1, a[`MANT_WIDTH-1:0]};
	assign mantB = {1'b1, b[`MANT_WIDTH-1:0]};

	always_comb
	begin
		mantProd = {{(`MANT_WIDTH+1){1'b0}}, mantA} * {{(`MANT_WIDTH+1){1'b0}}, mantB};
		// Product of two normals lies in [1, 4).
		norm = mantProd[2*`MANT_WIDTH+1];
		if (norm)
			mantOut = mantProd[2*`MANT_WIDTH -: `MANT_WIDTH];
		else
			mantOut = mantProd[2*`MANT_WIDTH-1 -: `MANT_WIDTH];
		expSum = {2'b00, expA} + {2'b00, expB} - Bias + {{(`EXP_WIDTH+1){1'b0}}, norm};

		// Zero, denormal operands and underflow all flush to +0.
		if (expA == '0 || expB == '0 || expSum[`EXP_WIDTH+1] || expSum == '0)
			product = '0;
		else
			product = {a[`FLOAT_WIDTH-1] ^ b[`FLOAT_WIDTH-1], expSum[`EXP_WIDTH-1:0], mantOut};
	end
endmodule

`default_nettype wire

// ==== design/macBus.sv ====
`timescale 1ns/1ps
`default_nettype none

interface macBus;
	logic clear;
	logic accumulate;
	logic useBias;
	logic finish;

	modport control (
		output clear,
		output accumulate,
		output useBias,
		output finish
	);

	modport sink (
		input clear,
		input accumulate,
		input useBias,
		input finish
	);
endinterface

`default_nettype wire

// ==== design/neuronPkg.sv ====
`default_nettype none

`include "neuron_params.svh"

package neuronPkg;

	// One slot per input plus the bias slot.
	typedef logic [$clog2(`NUM_INPUTS + 1)-1:0] weightIndex;

	typedef enum logic [1:0] {
		idle,
		collect,
		addBias,
		finish
	} controlState;

endpackage

`default_nettype wire

// ==== design/floatPkg.sv ====
`default_nettype none

`include "neuron_params.svh"

package floatPkg;

	// Full single precision word.
	typedef logic [`FLOAT_WIDTH-1:0] floatWord;

	// Biased exponent field.
	typedef logic [`EXP_WIDTH-1:0] floatExp;

	// Mantissa with the hidden bit restored.
	typedef logic [`MANT_WIDTH:0] floatMant;

endpackage

`default_nettype wire

// ==== design/neuron_params.svh ====
`ifndef NEURON_PARAMS_SVH
`define NEURON_PARAMS_SVH

// Activations per neuron.
`define NUM_INPUTS 15

// IEEE-754 single precision fields.
`define FLOAT_WIDTH 32
`define EXP_WIDTH 8
`define MANT_WIDTH 23

`endif
